// ==== verilog.f ====
+incdir+hw
hw/cdc_pkg.sv
hw/apb_if.sv
hw/cdc_apb_regs.sv
hw/value_deliver.sv
hw/value_transmitter.sv
hw/cdc_xfer_top.sv
tb/tb_cdc_xfer.sv

// ==== tb/tb_cdc_xfer.sv ====
`timescale 1ns/1ps

module tb_cdc_xfer
    import cdc_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 40 * 60 + 200;   // 40 transfers of 60 cycles plus margin.
    localparam int STREAM_LEN     = 20;

    logic        clk_a;
    logic        rst_a_n;
    logic        clk_b;
    logic        rst_b_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        value_out_ack;
    logic        pulse_out;
    xfer_value_t value_out;

    // expected response of the access in flight.
    logic        chk_rdata;
    logic [31:0] exp_rdata;
    logic        exp_err;

    xfer_value_t accepted_q[$];   // accepted values with the oldest first.
    xfer_value_t head_value;
    int          pending;
    int          accepted_count;
    xfer_value_t last_accepted;
    logic        end_check;

    integer      stim_seed;
    integer      ack_seed;
    int          cycle_count;

    cdc_xfer_top i_cdc_xfer_top (
        .clk_a         (clk_a),
        .rst_a_n       (rst_a_n),
        .clk_b         (clk_b),
        .rst_b_n       (rst_b_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .value_out_ack (value_out_ack),
        .pulse_out     (pulse_out),
        .value_out     (value_out)
    );

    // ------------------------------------------------------------
    // clocks and resets
    // ------------------------------------------------------------

    initial begin
        clk_a = 1'b0;
        forever begin
            #20 clk_a = ~clk_a;
        end
    end

    initial begin
        clk_b = 1'b0;
        #13;   // unrelated phase.
        forever begin
            #33 clk_b = ~clk_b;
        end
    end

    initial begin
        rst_a_n = 1'b0;
        repeat (4) @(posedge clk_a);
        #2 rst_a_n = 1'b1;
    end

    initial begin
        rst_b_n = 1'b0;
        repeat (4) @(posedge clk_b);
        #2 rst_b_n = 1'b1;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic void refresh_head();
        pending    = accepted_q.size();
        head_value = (pending > 0) ? accepted_q[0] : '0;
    endfunction

    // starts and ends a little after a rising clk_a edge.
    task automatic apb_access(
        input  logic        is_write,
        input  logic [3:0]  addr,
        input  logic [31:0] wdata,
        input  logic        check_data,
        input  logic [31:0] expect_data,
        input  logic        expect_err,
        output logic [31:0] rdata
    );
        psel      = 1'b1;
        penable   = 1'b0;
        pwrite    = is_write;
        paddr     = addr;
        pwdata    = wdata;
        chk_rdata = check_data;
        exp_rdata = expect_data;
        exp_err   = expect_err;
        @(posedge clk_a);
        #2;
        penable = 1'b1;
        @(negedge clk_a);
        while (!pready) begin
            @(negedge clk_a);
        end
        rdata = prdata;
        @(posedge clk_a);
        #2;
        psel      = 1'b0;
        penable   = 1'b0;
        chk_rdata = 1'b0;
    endtask

    task automatic read_reg(
        input  logic [3:0]  addr,
        input  logic        check_data,
        input  logic [31:0] expect_data,
        input  logic        expect_err,
        output logic [31:0] rdata
    );
        apb_access(1'b0, addr, 32'h0, check_data, expect_data, expect_err, rdata);
    endtask

    task automatic write_data(input xfer_value_t value, input logic expect_err);
        logic [31:0] rdata;
        apb_access(1'b1, REG_DATA, 32'(value), 1'b0, 32'h0, expect_err, rdata);
        if (!expect_err) begin
            accepted_q.push_back(value);
            refresh_head();
            accepted_count++;
            last_accepted = value;
        end
    endtask

    // poll until not busy and then check COUNT against the accepted writes.
    task automatic wait_idle();
        logic [31:0] status;
        logic [31:0] rdata;
        status = 32'h1;
        while (status[0]) begin
            read_reg(REG_STATUS, 1'b0, 32'h0, 1'b0, status);
        end
        read_reg(REG_COUNT, 1'b1, 32'(xfer_count_t'(accepted_count)), 1'b0, rdata);
    endtask

    // ------------------------------------------------------------
    // consumer and scoreboard in clk_b
    // ------------------------------------------------------------

    initial begin
        int ack_delay;
        value_out_ack = 1'b0;
        ack_seed      = 27766;
        forever begin
            @(posedge clk_b);
            #2;
            if (pulse_out) begin
                ack_delay = $random(ack_seed) & 3;   // 0 to 3 cycles.
                repeat (ack_delay) begin
                    @(posedge clk_b);
                    #2;
                end
                value_out_ack = 1'b1;
                @(posedge clk_b);
                #2;
                value_out_ack = 1'b0;
            end
        end
    end

    always @(posedge clk_b) begin
        if (rst_b_n && pulse_out && pending > 0) begin
            void'(accepted_q.pop_front());   // head was checked at this edge.
            refresh_head();
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    a_pready: assert property (@(posedge clk_a) disable iff (!rst_a_n)
        pready == (psel && penable))
        else abort_run($sformatf("ERROR %0t: pready does not follow the access phase", $time));

    a_idle_err: assert property (@(posedge clk_a) disable iff (!rst_a_n)
        !(psel && penable) |-> !pslverr)
        else abort_run($sformatf("ERROR %0t: pslverr high outside an access", $time));

    a_err: assert property (@(posedge clk_a) disable iff (!rst_a_n)
        (psel && penable && pready) |-> (pslverr == exp_err))
        else abort_run($sformatf("ERROR %0t: pslverr %b at addr %h, expected %b",
            $time, $sampled(pslverr), $sampled(paddr), $sampled(exp_err)));

    a_rdata: assert property (@(posedge clk_a) disable iff (!rst_a_n)
        (psel && penable && pready && chk_rdata) |-> (prdata == exp_rdata))
        else abort_run($sformatf("ERROR %0t: prdata %h at addr %h, expected %h",
            $time, $sampled(prdata), $sampled(paddr), $sampled(exp_rdata)));

    a_drained: assert property (@(posedge clk_a) end_check |-> (pending == 0))
        else abort_run($sformatf("ERROR %0t: %0d accepted values never delivered",
            $time, $sampled(pending)));

    a_reset_out: assert property (@(posedge clk_b)
        $rose(rst_b_n) |-> (!pulse_out && value_out == '0))
        else abort_run($sformatf("ERROR %0t: clk_b outputs not idle after reset", $time));

    a_pulse_len: assert property (@(posedge clk_b) disable iff (!rst_b_n)
        pulse_out |=> !pulse_out)
        else abort_run($sformatf("ERROR %0t: pulse_out longer than one cycle", $time));

    a_head: assert property (@(posedge clk_b) disable iff (!rst_b_n)
        pulse_out |-> (pending > 0 && value_out == head_value))
        else abort_run($sformatf("ERROR %0t: value_out %h at pulse_out, expected %h (%0d queued)",
            $time, $sampled(value_out), $sampled(head_value), $sampled(pending)));

    a_hold: assert property (@(posedge clk_b) disable iff (!rst_b_n)
        !value_out_ack |=> (pulse_out || $stable(value_out)))
        else abort_run($sformatf("ERROR %0t: value_out changed without an ack", $time));

    a_clear: assert property (@(posedge clk_b) disable iff (!rst_b_n)
        value_out_ack |=> (pulse_out || value_out == '0))
        else abort_run($sformatf("ERROR %0t: value_out %h not cleared after ack",
            $time, $sampled(value_out)));

    // ------------------------------------------------------------
    // timeout
    // ------------------------------------------------------------

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_a);
            cycle_count++;
        end
        abort_run($sformatf("timeout: the run did not finish within %0d clk_a cycles",
            TIMEOUT_CYCLES));
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    initial begin
        logic [31:0] rdata;
        xfer_value_t next_value;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        chk_rdata      = 1'b0;
        exp_rdata      = '0;
        exp_err        = 1'b0;
        end_check      = 1'b0;
        stim_seed      = 27766;
        accepted_count = 0;
        last_accepted  = '0;
        refresh_head();

        wait (rst_a_n && rst_b_n);
        @(posedge clk_a);
        #2;

        read_reg(REG_STATUS, 1'b1, 32'h0, 1'b0, rdata);
        read_reg(REG_COUNT, 1'b1, 32'h0, 1'b0, rdata);

        // busy right after the write so the second write bounces.
        next_value = xfer_value_t'($random(stim_seed));
        write_data(next_value, 1'b0);
        read_reg(REG_STATUS, 1'b1, 32'h1, 1'b0, rdata);
        write_data(~next_value, 1'b1);
        wait_idle();
        read_reg(REG_DATA, 1'b1, 32'(last_accepted), 1'b0, rdata);

        for (int i = 0; i < STREAM_LEN; i++) begin
            next_value = xfer_value_t'($random(stim_seed));
            write_data(next_value, 1'b0);
            read_reg(REG_STATUS, 1'b1, 32'h1, 1'b0, rdata);
            wait_idle();
        end

        // unmapped address in both directions.
        read_reg(4'hC, 1'b1, 32'h0, 1'b1, rdata);
        apb_access(1'b1, 4'hC, 32'h5A, 1'b0, 32'h0, 1'b1, rdata);
        read_reg(REG_DATA, 1'b1, 32'(last_accepted), 1'b0, rdata);
        read_reg(REG_COUNT, 1'b1, 32'(xfer_count_t'(accepted_count)), 1'b0, rdata);

        repeat (4) @(posedge clk_b);
        @(posedge clk_a);
        #2;
        end_check = 1'b1;
        repeat (2) @(posedge clk_a);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== hw/cdc_xfer_top.sv ====
`timescale 1ns/1ps

module cdc_xfer_top
    import cdc_pkg::*;
(
    input  logic        clk_a,
    input  logic        rst_a_n,
    input  logic        clk_b,
    input  logic        rst_b_n,

    // apb slave, clk_a domain.
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,

    // consumer side, clk_b domain.
    input  logic        value_out_ack,
    output logic        pulse_out,
    output xfer_value_t value_out
);

    logic        pulse_in;
    xfer_value_t value_in;
    logic        delivered;

    apb_if i_apb ();

    // ------------------------------------------------------------
    // plain ports onto the bus
    // ------------------------------------------------------------

    assign i_apb.psel    = psel;
    assign i_apb.penable = penable;
    assign i_apb.pwrite  = pwrite;
    assign i_apb.paddr   = paddr;
    assign i_apb.pwdata  = pwdata;

    assign prdata  = i_apb.prdata;
    assign pready  = i_apb.pready;
    assign pslverr = i_apb.pslverr;

    cdc_apb_regs i_cdc_apb_regs (
        .clk_a     (clk_a),
        .rst_a_n   (rst_a_n),
        .apb       (i_apb.slave),
        .delivered (delivered),
        .pulse_in  (pulse_in),
        .value_in  (value_in)
    );

    value_transmitter i_value_transmitter (
        .clk_a         (clk_a),
        .rst_a_n       (rst_a_n),
        .pulse_in      (pulse_in),
        .value_in      (value_in),
        .delivered     (delivered),
        .clk_b         (clk_b),
        .rst_b_n       (rst_b_n),
        .value_out_ack (value_out_ack),
        .pulse_out     (pulse_out),
        .value_out     (value_out)
    );

endmodule

// ==== hw/value_transmitter.sv ====
`timescale 1ns/1ps

module value_transmitter
    import cdc_pkg::*;
(
    input  logic        clk_a,
    input  logic        rst_a_n,
    input  logic        pulse_in,
    input  xfer_value_t value_in,
    output logic        delivered,
    input  logic        clk_b,
    input  logic        rst_b_n,
    input  logic        value_out_ack,   // consumer has taken value_out.
    output logic        pulse_out,
    output xfer_value_t value_out
);

    logic        pulse_in_q;
    xfer_value_t value_in_q;

    logic        pulse_b;      // crossed pulse, clk_b.
    xfer_value_t value_b;      // crossed value, valid with pulse_b.

    // ------------------------------------------------------------
    // clk_a request register
    // ------------------------------------------------------------

    always_ff @(posedge clk_a or negedge rst_a_n) begin
        if (!rst_a_n) begin
            pulse_in_q <= 1'b0;
        end else begin
            pulse_in_q <= pulse_in;
        end
    end

    always_ff @(posedge clk_a) begin
        if (pulse_in) begin
            value_in_q <= value_in;
        end
    end

    value_deliver #(
        .WIDTH ($bits(xfer_value_t))
    ) i_value_deliver (
        .clk_a     (clk_a),
        .rst_a_n   (rst_a_n),
        .clk_b     (clk_b),
        .rst_b_n   (rst_b_n),
        .pulse_in  (pulse_in_q),
        .value_in  (value_in_q),
        .pulse_out (pulse_b),
        .value_out (value_b),
        .done      (delivered)
    );

    // ------------------------------------------------------------
    // clk_b output stage
    // ------------------------------------------------------------

    always_ff @(posedge clk_b or negedge rst_b_n) begin
        if (!rst_b_n) begin
            pulse_out <= 1'b0;
        end else begin
            pulse_out <= pulse_b;
        end
    end

    // a new delivery wins over a pending ack.
    always_ff @(posedge clk_b or negedge rst_b_n) begin
        if (!rst_b_n) begin
            value_out <= '0;
        end else if (pulse_b) begin
            value_out <= value_b;
        end else if (value_out_ack) begin
            value_out <= '0;
        end
    end

endmodule

// ==== hw/value_deliver.sv ====
`include "cdc_settings.svh"
`timescale 1ns/1ps

module value_deliver
    import cdc_pkg::*;
#(
    parameter int WIDTH = `XFER_WIDTH
) (
    input  logic             clk_a,
    input  logic             rst_a_n,
    input  logic             clk_b,
    input  logic             rst_b_n,
    input  logic             pulse_in,
    input  logic [WIDTH-1:0] value_in,
    output logic             pulse_out,
    output logic [WIDTH-1:0] value_out,
    output logic             done
);

    logic             req_tgl;    // flips once per request.
    logic [WIDTH-1:0] hold_q;     // stable until clk_b has taken it.

    sync_chain_t      req_sync;
    logic             req_seen;   // receive toggle in clk_b.

    sync_chain_t      ack_sync;
    logic             ack_seen;

    // ------------------------------------------------------------
    // clk_a launch
    // ------------------------------------------------------------

    always_ff @(posedge clk_a or negedge rst_a_n) begin
        if (!rst_a_n) begin
            req_tgl <= 1'b0;
        end else if (pulse_in) begin
            req_tgl <= ~req_tgl;
        end
    end

    always_ff @(posedge clk_a) begin
        if (pulse_in) begin
            hold_q <= value_in;
        end
    end

    // ------------------------------------------------------------
    // clk_b receive
    // ------------------------------------------------------------

    always_ff @(posedge clk_b or negedge rst_b_n) begin
        if (!rst_b_n) begin
            req_sync <= '0;
            req_seen <= 1'b0;
        end else begin
            req_sync <= {req_sync[`SYNC_STAGES-2:0], req_tgl};
            req_seen <= req_sync[`SYNC_STAGES-1];
        end
    end

    // one clk_b cycle per toggle edge.
    assign pulse_out = req_sync[`SYNC_STAGES-1] ^ req_seen;

    // hold_q does not move while the toggle is in flight.
    assign value_out = hold_q;

    // ------------------------------------------------------------
    // return toggle into clk_a
    // ------------------------------------------------------------

    always_ff @(posedge clk_a or negedge rst_a_n) begin
        if (!rst_a_n) begin
            ack_sync <= '0;
            ack_seen <= 1'b0;
        end else begin
            ack_sync <= {ack_sync[`SYNC_STAGES-2:0], req_seen};
            ack_seen <= ack_sync[`SYNC_STAGES-1];
        end
    end

    assign done = ack_sync[`SYNC_STAGES-1] ^ ack_seen;

endmodule

// ==== hw/cdc_apb_regs.sv ====
`timescale 1ns/1ps

module cdc_apb_regs
    import cdc_pkg::*;
(
    input  logic        clk_a,
    input  logic        rst_a_n,
    apb_if.slave        apb,
    input  logic        delivered,
    output logic        pulse_in,
    output xfer_value_t value_in
);

    logic        access;     // apb access phase.
    logic        data_wr;
    logic        accept;
    logic        reject;
    logic        addr_hit;
    logic [31:0] rd_mux;

    xfer_value_t data_q;     // last accepted value.
    logic        busy_q;
    xfer_count_t count_q;

    // ------------------------------------------------------------
    // access decode
    // ------------------------------------------------------------

    assign access  = apb.psel & apb.penable;
    assign data_wr = access & apb.pwrite & (apb.paddr == REG_DATA);
    assign accept  = data_wr & ~busy_q;
    assign reject  = data_wr & busy_q;   // dropped, only pslverr is seen.

    always_comb begin
        addr_hit = 1'b1;
        rd_mux   = '0;
        case (apb.paddr)
            REG_DATA:   rd_mux = 32'(data_q);
            REG_STATUS: rd_mux = {31'b0, busy_q};
            REG_COUNT:  rd_mux = 32'(count_q);
            default:    addr_hit = 1'b0;
        endcase
    end

    // no wait states.
    assign apb.pready  = access;
    assign apb.pslverr = access & (~addr_hit | reject);

    // error responses read back zero.
    assign apb.prdata = (access & ~apb.pwrite & addr_hit) ? rd_mux : '0;

    // the request leaves in the access phase itself.
    assign pulse_in = accept;
    assign value_in = xfer_value_t'(apb.pwdata);

    // ------------------------------------------------------------
    // register state
    // ------------------------------------------------------------

    always_ff @(posedge clk_a) begin
        if (accept) begin
            data_q <= value_in;
        end
    end

    // set on an accepted write, cleared when clk_b has the value.
    always_ff @(posedge clk_a or negedge rst_a_n) begin
        if (!rst_a_n) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (delivered) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_a or negedge rst_a_n) begin
        if (!rst_a_n) begin
            count_q <= '0;
        end else if (delivered) begin
            count_q <= count_q + 1'b1;   // wraps.
        end
    end

endmodule

// ==== hw/apb_if.sv ====
`timescale 1ns/1ps

interface apb_if;

    // request side, driven by the master.
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;

    // response side, driven by the slave.
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    modport master (
        output psel,
        output penable,
        output pwrite,
        output paddr,
        output pwdata,
        input  prdata,
        input  pready,
        input  pslverr
    );

    modport slave (
        input  psel,
        input  penable,
        input  pwrite,
        input  paddr,
        input  pwdata,
        output prdata,
        output pready,
        output pslverr
    );

endinterface

// ==== hw/cdc_pkg.sv ====
package cdc_pkg;

    `include "cdc_settings.svh"

    // ------------------------------------------------------------
    // payload and status types
    // ------------------------------------------------------------

    typedef logic [`XFER_WIDTH-1:0] xfer_value_t;   // one value in flight.

    typedef logic [`COUNT_WIDTH-1:0] xfer_count_t;  // wraps at 2**COUNT_WIDTH.

    // one synchronizer chain, oldest stage in the msb.
    typedef logic [`SYNC_STAGES-1:0] sync_chain_t;

    // ------------------------------------------------------------
    // register map
    // ------------------------------------------------------------

    // byte addresses on the apb slave.
    typedef enum logic [3:0] {
        REG_DATA   = 4'h0,  // write starts a transfer.
        REG_STATUS = 4'h4,  // bit 0 is busy.
        REG_COUNT  = 4'h8   // completed deliveries.
    } reg_addr_e;

endpackage

// ==== hw/cdc_settings.svh ====
`ifndef CDC_SETTINGS_SVH
`define CDC_SETTINGS_SVH

// ------------------------------------------------------------
// transfer path sizing
// ------------------------------------------------------------

// bits in one transferred value.
`define XFER_WIDTH 8

// flip-flops in each synchronizer chain, both directions.
`define SYNC_STAGES 2

// ------------------------------------------------------------
// status sizing
// ------------------------------------------------------------

// completed delivery counter, wraps.
`define COUNT_WIDTH 8

`endif
